// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= pwo_tb
RTL_TOP   ?= pwo_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
PASS_MSG  ?= Done: no errors

RTL_SRCS := $(filter src/%.sv,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src/abr_params_pkg.sv ====
// Shared widths, modulus and polynomial sizing, imported by every pointwise engine block
package abr_params_pkg;

    // ========================================================================
    // Coefficient and memory word format
    // ========================================================================

    // One coefficient mod q
    localparam int coef_width = 23;

    // Slot per coefficient in a memory word, top bit always zero
    localparam int coef_slot = 24;

    // Coefficients per memory word
    localparam int num_lanes = 4;

    localparam int mem_data_width = num_lanes * coef_slot;
    localparam int mem_addr_width = 10;

    // 256 coefficients, four per word
    localparam int poly_words = 64;

    // Dilithium modulus, 2^23 - 2^13 + 1
    localparam logic [coef_width-1:0] dilithium_q = 23'd8380417;

    // Register stages inside one arithmetic lane
    localparam int lane_latency = 2;

    // ========================================================================
    // Basic types
    // ========================================================================

    typedef logic [coef_width-1:0]     coef_t;
    typedef logic [mem_data_width-1:0] mem_data_t;
    typedef logic [mem_addr_width-1:0] mem_addr_t;

endpackage

// ==== src/ntt_defines_pkg.sv ====
// Mode and memory command encodings plus the structs passed between pointwise engine blocks
package ntt_defines_pkg;

    import abr_params_pkg::*;

    // Pointwise multiply, add, subtract
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_e;

    typedef enum logic [1:0] {
        rw_idle  = 2'd0,
        rw_read  = 2'd1,
        rw_write = 2'd2
    } rw_cmd_e;

    // Memory request, read or write at one word address
    typedef struct packed {
        rw_cmd_e   rd_wr_en;
        mem_addr_t addr;
    } mem_if_t;

    // Base word addresses of the three polynomials
    typedef struct packed {
        mem_addr_t addr_a;
        mem_addr_t addr_b;
        mem_addr_t addr_c;
    } pwo_mem_addr_t;

    // Operands of one lane, w is the accumulate term
    typedef struct packed {
        coef_t u;
        coef_t v;
        coef_t w;
    } lane_opnd_t;

    // Travels with each word through the pipeline
    typedef struct packed {
        logic      valid;
        logic      acc;
        mem_addr_t addr;
    } pwo_tag_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        run   = 2'd1,
        drain = 2'd2
    } ctrl_state_e;

endpackage

// ==== src/pwo_ctrl.sv ====
// Pointwise operation controller that latches a request, walks the operand words and reports done
`timescale 1ns/100ps

module pwo_ctrl (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           enable_i,
    input  ntt_defines_pkg::pwo_mode_e     mode_i,
    input  logic                           accumulate_i,
    input  logic                           sampler_valid_i,
    input  ntt_defines_pkg::pwo_mem_addr_t base_addr_i,
    input  logic                           wr_valid_i,
    output ntt_defines_pkg::pwo_mode_e     mode_o,
    output ntt_defines_pkg::mem_if_t       a_rd_req_o,
    output ntt_defines_pkg::mem_if_t       b_rd_req_o,
    output ntt_defines_pkg::mem_if_t       c_rd_req_o,
    output ntt_defines_pkg::pwo_tag_t      tag_o,
    output logic                           busy_o,
    output logic                           done_o
);

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    typedef logic [$clog2(poly_words)-1:0] word_idx_t;

    ctrl_state_e   state;
    pwo_mode_e     mode_q;
    logic          acc_q;
    pwo_mem_addr_t base_q;
    word_idx_t     rd_idx;
    word_idx_t     wr_cnt;
    logic          done_q;
    logic          issue;
    logic          acc_pwm;
    logic          last_rd;
    logic          last_wr;

    // Reads only go out while the sampler has data
    assign issue   = (state == run) && sampler_valid_i;
    assign acc_pwm = acc_q && (mode_q == pwm);
    assign last_rd = issue && (rd_idx == word_idx_t'(poly_words - 1));
    assign last_wr = (state == drain) && wr_valid_i &&
                     (wr_cnt == word_idx_t'(poly_words - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= idle;
            mode_q <= pwm;
            acc_q  <= 1'b0;
            base_q <= '0;
            rd_idx <= '0;
            wr_cnt <= '0;
            done_q <= 1'b0;
        end else if (zeroize_i) begin
            state  <= idle;
            mode_q <= pwm;
            acc_q  <= 1'b0;
            base_q <= '0;
            rd_idx <= '0;
            wr_cnt <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= last_wr;
            // Both counters wrap back to zero after a full polynomial
            if (issue) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (wr_valid_i && (state != idle)) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            case (state)
                idle: begin
                    if (enable_i) begin
                        state  <= run;
                        mode_q <= mode_i;
                        acc_q  <= accumulate_i;
                        base_q <= base_addr_i;
                    end
                end
                run: begin
                    if (last_rd) begin
                        state <= drain;
                    end
                end
                drain: begin
                    if (last_wr) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        a_rd_req_o.rd_wr_en = issue ? rw_read : rw_idle;
        a_rd_req_o.addr     = base_q.addr_a + mem_addr_t'(rd_idx);
        b_rd_req_o.rd_wr_en = issue ? rw_read : rw_idle;
        b_rd_req_o.addr     = base_q.addr_b + mem_addr_t'(rd_idx);
        // Destination is only read back when accumulating a product
        c_rd_req_o.rd_wr_en = (issue && acc_pwm) ? rw_read : rw_idle;
        c_rd_req_o.addr     = base_q.addr_c + mem_addr_t'(rd_idx);
        tag_o.valid         = issue;
        tag_o.acc           = acc_pwm;
        tag_o.addr          = base_q.addr_c + mem_addr_t'(rd_idx);
    end

    assign mode_o = mode_q;
    assign busy_o = (state != idle);
    assign done_o = done_q;

    // The walk only ends on its last word
    a_walk_complete: assert property (@(posedge clk) disable iff (!reset_n)
        (state != run) |-> (rd_idx == '0));

    // Done follows a write and never overlaps a read
    a_done_clean: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        done_o |-> ($past(wr_valid_i) && a_rd_req_o.rd_wr_en == rw_idle));

endmodule

// ==== src/pwo_lane.sv ====
// One coefficient lane doing modular add, subtract or multiply-accumulate in two stages
`timescale 1ns/100ps

module pwo_lane (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  ntt_defines_pkg::pwo_mode_e  mode_i,
    input  ntt_defines_pkg::lane_opnd_t opnd_i,
    output abr_params_pkg::coef_t       result_o
);

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    logic [2*coef_width-1:0] st1_d;
    logic [2*coef_width-1:0] st1_q;
    logic [36:0]             fold1;
    logic [27:0]             fold2;
    logic [coef_width:0]     fold3;
    logic [coef_width:0]     red_in;
    coef_t                   red_out;
    coef_t                   result_q;

    // ========================================================================
    // Stage 1, raw sum, difference or product
    // ========================================================================

    always_comb begin
        case (mode_i)
            pwm: st1_d = (2*coef_width)'(opnd_i.u) * (2*coef_width)'(opnd_i.v) +
                         (2*coef_width)'(opnd_i.w);
            // Adding q keeps the difference positive
            pws: st1_d = (2*coef_width)'(opnd_i.u) + (2*coef_width)'(dilithium_q) -
                         (2*coef_width)'(opnd_i.v);
            default: st1_d = (2*coef_width)'(opnd_i.u) + (2*coef_width)'(opnd_i.v);
        endcase
    end

    // ========================================================================
    // Stage 2, reduction into 0 .. q-1
    // ========================================================================

    // Fold the high part with 2^23 = 2^13 - 1 mod q until below 2q
    assign fold1 = 37'(st1_q[2*coef_width-1:coef_width]) * 37'(13'h1fff) +
                   37'(st1_q[coef_width-1:0]);
    assign fold2 = 28'(fold1[36:coef_width]) * 28'(13'h1fff) + 28'(fold1[coef_width-1:0]);
    assign fold3 = (coef_width+1)'(fold2[27:coef_width]) * (coef_width+1)'(13'h1fff) +
                   (coef_width+1)'(fold2[coef_width-1:0]);

    // Add and subtract already sit below 2q
    assign red_in  = (mode_i == pwm) ? fold3 : st1_q[coef_width:0];
    assign red_out = (red_in >= {1'b0, dilithium_q}) ? coef_t'(red_in - {1'b0, dilithium_q})
                                                     : coef_t'(red_in);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            st1_q    <= '0;
            result_q <= '0;
        end else if (zeroize_i) begin
            st1_q    <= '0;
            result_q <= '0;
        end else begin
            st1_q    <= st1_d;
            result_q <= red_out;
        end
    end

    assign result_o = result_q;

    // Fully reduced whatever the mode
    a_result_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        result_o < dilithium_q);

endmodule

// ==== src/pwo_operand_unpack.sv ====
// Operand feeder that aligns the tag with memory read data and splits each word into lanes
`timescale 1ns/100ps

module pwo_operand_unpack (
    input  logic                                                    clk,
    input  logic                                                    reset_n,
    input  logic                                                    zeroize_i,
    input  ntt_defines_pkg::pwo_tag_t                               tag_i,
    input  abr_params_pkg::mem_data_t                               a_data_i,
    input  abr_params_pkg::mem_data_t                               b_data_i,
    input  abr_params_pkg::mem_data_t                               c_data_i,
    output ntt_defines_pkg::lane_opnd_t [abr_params_pkg::num_lanes-1:0] opnd_o,
    output ntt_defines_pkg::pwo_tag_t                               tag_o
);

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    pwo_tag_t  tag_d1;
    pwo_tag_t  tag_q;
    mem_data_t a_q;
    mem_data_t b_q;
    mem_data_t c_q;

    // Tag waits one cycle for the memory, then lands with the data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_d1 <= '0;
            tag_q  <= '0;
            a_q    <= '0;
            b_q    <= '0;
            c_q    <= '0;
        end else if (zeroize_i) begin
            tag_d1 <= '0;
            tag_q  <= '0;
            a_q    <= '0;
            b_q    <= '0;
            c_q    <= '0;
        end else begin
            tag_d1 <= tag_i;
            tag_q  <= tag_d1;
            a_q    <= a_data_i;
            b_q    <= b_data_i;
            c_q    <= c_data_i;
        end
    end

    // Drop the spare top bit of each slot
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            opnd_o[i].u = a_q[i*coef_slot +: coef_width];
            opnd_o[i].v = b_q[i*coef_slot +: coef_width];
            // No accumulate term for add, subtract or plain multiply
            opnd_o[i].w = tag_q.acc ? c_q[i*coef_slot +: coef_width] : '0;
        end
    end

    assign tag_o = tag_q;

endmodule

// ==== src/pwo_result_pack.sv ====
// Result drain that aligns the write tag with lane latency and registers the packed write
`timescale 1ns/100ps

module pwo_result_pack (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic                                              zeroize_i,
    input  ntt_defines_pkg::pwo_tag_t                         tag_i,
    input  abr_params_pkg::coef_t [abr_params_pkg::num_lanes-1:0] result_i,
    output ntt_defines_pkg::mem_if_t                          wr_req_o,
    output abr_params_pkg::mem_data_t                         wr_data_o,
    output logic                                              wr_valid_o
);

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    pwo_tag_t [lane_latency-1:0] tag_pipe;
    pwo_tag_t                    tag_aligned;
    mem_data_t                   wr_data_d;
    mem_if_t                     wr_req_q;
    mem_data_t                   wr_data_q;

    assign tag_aligned = tag_pipe[lane_latency-1];

    // Repack lanes with a zero in each slot's top bit
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            wr_data_d[i*coef_slot +: coef_slot] = {1'b0, result_i[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_pipe  <= '0;
            wr_req_q  <= '0;
            wr_data_q <= '0;
        end else if (zeroize_i) begin
            tag_pipe  <= '0;
            wr_req_q  <= '0;
            wr_data_q <= '0;
        end else begin
            tag_pipe          <= {tag_pipe[lane_latency-2:0], tag_i};
            wr_req_q.rd_wr_en <= tag_aligned.valid ? rw_write : rw_idle;
            wr_req_q.addr     <= tag_aligned.addr;
            wr_data_q         <= wr_data_d;
        end
    end

    assign wr_req_o   = wr_req_q;
    assign wr_data_o  = wr_data_q;
    assign wr_valid_o = (wr_req_q.rd_wr_en == rw_write);

    // Back to back writes always target different words
    a_no_repeat_addr: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (wr_valid_o && $past(wr_valid_o)) |-> (wr_req_o.addr != $past(wr_req_o.addr)));

endmodule

// ==== src/pwo_top.sv ====
// Pointwise engine top tying the controller, operand feeder, lanes and drain to memory ports
`timescale 1ns/100ps

module pwo_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           enable_i,
    input  ntt_defines_pkg::pwo_mode_e     mode_i,
    input  logic                           accumulate_i,
    input  logic                           sampler_valid_i,
    input  ntt_defines_pkg::pwo_mem_addr_t base_addr_i,
    input  abr_params_pkg::mem_data_t      mem_rd_data_i,
    input  abr_params_pkg::mem_data_t      pwm_a_rd_data_i,
    input  abr_params_pkg::mem_data_t      pwm_b_rd_data_i,
    output ntt_defines_pkg::mem_if_t       mem_wr_req_o,
    output abr_params_pkg::mem_data_t      mem_wr_data_o,
    output ntt_defines_pkg::mem_if_t       mem_rd_req_o,
    output ntt_defines_pkg::mem_if_t       pwm_a_rd_req_o,
    output ntt_defines_pkg::mem_if_t       pwm_b_rd_req_o,
    output logic                           busy_o,
    output logic                           done_o
);

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    pwo_mode_e                   lane_mode;
    pwo_tag_t                    rd_tag;
    pwo_tag_t                    opnd_tag;
    lane_opnd_t [num_lanes-1:0]  opnd;
    coef_t [num_lanes-1:0]       lane_result;
    logic                        wr_valid;

    pwo_ctrl i_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .enable_i       (enable_i),
        .mode_i         (mode_i),
        .accumulate_i   (accumulate_i),
        .sampler_valid_i(sampler_valid_i),
        .base_addr_i    (base_addr_i),
        .wr_valid_i     (wr_valid),
        .mode_o         (lane_mode),
        .a_rd_req_o     (pwm_a_rd_req_o),
        .b_rd_req_o     (pwm_b_rd_req_o),
        .c_rd_req_o     (mem_rd_req_o),
        .tag_o          (rd_tag),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    // Shared memory read port carries the accumulate operand
    pwo_operand_unpack i_unpack (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .tag_i    (rd_tag),
        .a_data_i (pwm_a_rd_data_i),
        .b_data_i (pwm_b_rd_data_i),
        .c_data_i (mem_rd_data_i),
        .opnd_o   (opnd),
        .tag_o    (opnd_tag)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        pwo_lane i_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize_i(zeroize_i),
            .mode_i   (lane_mode),
            .opnd_i   (opnd[i]),
            .result_o (lane_result[i])
        );
    end

    pwo_result_pack i_pack (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .tag_i     (opnd_tag),
        .result_i  (lane_result),
        .wr_req_o  (mem_wr_req_o),
        .wr_data_o (mem_wr_data_o),
        .wr_valid_o(wr_valid)
    );

endmodule

// ==== tb.f ====
+incdir+test
src/abr_params_pkg.sv
src/ntt_defines_pkg.sv
src/pwo_ctrl.sv
src/pwo_operand_unpack.sv
src/pwo_lane.sv
src/pwo_result_pack.sv
src/pwo_top.sv
test/pwo_tb.sv

// ==== test/pwo_tests.svh ====
// Directed tests and reference modular model, included inside the pointwise testbench module

function automatic coef_t rand_coef();
    return coef_t'($urandom % 32'(dilithium_q));
endfunction

// Reference result in 64-bit arithmetic from the mode rules
function automatic coef_t ref_coef(input pwo_mode_e mode, input logic acc, input coef_t u,
                                   input coef_t v, input coef_t w);
    longint unsigned q64;
    longint unsigned r;
    q64 = 64'(dilithium_q);
    case (mode)
        pwa: r = (64'(u) + 64'(v)) % q64;
        pws: r = (64'(u) + q64 - 64'(v)) % q64;
        default: r = (64'(u) * 64'(v) + (acc ? 64'(w) : 64'd0)) % q64;
    endcase
    return coef_t'(r);
endfunction

function automatic int error_total();
    return mon_errors + chk_errors;
endfunction

task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
    if (got !== want) begin
        chk_errors++;
        $display("[FAIL] %s: expected %0h, got %0h", name, want, got);
    end
endtask

task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (error_total() == err_start) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: failed with %0d errors", name, error_total() - err_start);
    end
endtask

// Word 0 holds the corner cases of v > u and the largest product
task automatic load_polys(input pwo_mem_addr_t base);
    coef_t u;
    coef_t v;
    for (int k = 0; k < poly_words; k++) begin
        for (int i = 0; i < num_lanes; i++) begin
            u = rand_coef();
            v = (k == 0) ? dilithium_q - 23'd1 : rand_coef();
            if (k == 0) begin
                u = (i < 2) ? coef_t'(i) : dilithium_q - 23'd1;
            end
            mem_a[base.addr_a + mem_addr_t'(k)][i*coef_slot +: coef_slot] = {1'b0, u};
            mem_b[base.addr_b + mem_addr_t'(k)][i*coef_slot +: coef_slot] = {1'b0, v};
            c_init[base.addr_c + mem_addr_t'(k)][i*coef_slot +: coef_slot] = {1'b0, rand_coef()};
        end
    end
    @(posedge clk);
    c_load <= 1'b1;
    @(posedge clk);
    c_load <= 1'b0;
endtask

task automatic start_op(input pwo_mode_e mode, input logic acc, input pwo_mem_addr_t base);
    @(posedge clk);
    mode_i       <= mode;
    accumulate_i <= acc;
    base_addr_i  <= base;
    enable_i     <= 1'b1;
    @(posedge clk);
    enable_i <= 1'b0;
endtask

// Compare the whole destination polynomial against the model
task automatic check_poly(input pwo_mode_e mode, input logic acc, input pwo_mem_addr_t base);
    mem_addr_t            ca;
    coef_t                u;
    coef_t                v;
    coef_t                w;
    logic [coef_slot-1:0] got;
    for (int k = 0; k < poly_words; k++) begin
        ca = base.addr_c + mem_addr_t'(k);
        for (int i = 0; i < num_lanes; i++) begin
            u   = mem_a[base.addr_a + mem_addr_t'(k)][i*coef_slot +: coef_width];
            v   = mem_b[base.addr_b + mem_addr_t'(k)][i*coef_slot +: coef_width];
            w   = c_init[ca][i*coef_slot +: coef_width];
            got = mem_c[ca][i*coef_slot +: coef_slot];
            if (got !== {1'b0, ref_coef(mode, acc, u, v, w)}) begin
                chk_errors++;
                $display("[FAIL] mem_c[%03h] lane %0d: expected %06h, got %06h",
                         ca, i, {1'b0, ref_coef(mode, acc, u, v, w)}, got);
            end
        end
    end
endtask

task automatic test_reset();
    int err_start;
    err_start = error_total();
    @(negedge clk);
    check_value("busy_o", 0, 32'(busy_o));
    check_value("done_o", 0, 32'(done_o));
    check_value("mem_rd_req_o.rd_wr_en", 32'(rw_idle), 32'(mem_rd_req_o.rd_wr_en));
    check_value("pwm_a_rd_req_o.rd_wr_en", 32'(rw_idle), 32'(pwm_a_rd_req_o.rd_wr_en));
    check_value("pwm_b_rd_req_o.rd_wr_en", 32'(rw_idle), 32'(pwm_b_rd_req_o.rd_wr_en));
    check_value("mem_wr_req_o.rd_wr_en", 32'(rw_idle), 32'(mem_wr_req_o.rd_wr_en));
    report_test("reset state", err_start);
endtask

// Full polynomial run with optional random sampler_valid gaps
task automatic test_pointwise(input string name, input pwo_mode_e mode, input logic acc,
                              input pwo_mem_addr_t base, input logic pause);
    int   err_start;
    int   wr_start;
    int   done_start;
    int   rd_start;
    int   pauses_left;
    logic hold;
    err_start   = error_total();
    wr_start    = wr_total;
    done_start  = done_total;
    rd_start    = c_rd_total;
    pauses_left = pause ? max_pause : 0;
    load_polys(base);
    start_op(mode, acc, base);
    do begin
        @(posedge clk);
        hold = (pauses_left > 0) && ($urandom_range(3, 0) == 0);
        if (hold) begin
            pauses_left--;
        end
        sampler_valid_i <= !hold;
        @(negedge clk);
    end while (!done_o);
    // Busy drops in the done cycle
    check_value("busy_o with done_o", 0, 32'(busy_o));
    @(posedge clk);
    sampler_valid_i <= 1'b1;
    @(negedge clk);
    check_value("mem_wr_req_o writes", 64, wr_total - wr_start);
    check_value("done_o pulses", 1, done_total - done_start);
    check_value("mem_rd_req_o reads", (acc && mode == pwm) ? 64 : 0, c_rd_total - rd_start);
    check_poly(mode, acc, base);
    report_test(name, err_start);
endtask

task automatic test_zeroize();
    int err_start;
    int wr_start;
    int done_start;
    err_start = error_total();
    load_polys({10'h080, 10'h0c0, 10'h100});
    start_op(pwm, 1'b1, {10'h080, 10'h0c0, 10'h100});
    // Far enough in that writes are already streaming
    repeat (30) @(posedge clk);
    @(negedge clk);
    check_value("busy_o before zeroize", 1, 32'(busy_o));
    @(posedge clk);
    zeroize_i <= 1'b1;
    @(posedge clk);
    zeroize_i <= 1'b0;
    @(negedge clk);
    check_value("busy_o", 0, 32'(busy_o));
    wr_start   = wr_total;
    done_start = done_total;
    repeat (20) @(negedge clk);
    check_value("mem_wr_req_o writes after zeroize", 0, wr_total - wr_start);
    check_value("done_o pulses after zeroize", 0, done_total - done_start);
    report_test("zeroize abort", err_start);
    test_pointwise("restart after zeroize", pws, 1'b0, {10'h1c0, 10'h200, 10'h240}, 1'b0);
endtask

// ==== test/pwo_tb.sv ====
// Testbench for the pointwise engine; run it as the simulation top with the tests header included
`timescale 1ns/100ps

module pwo_tb;

    import abr_params_pkg::*;
    import ntt_defines_pkg::*;

    localparam int num_tests   = 8;
    localparam int max_pause   = 64;
    localparam int cycle_limit = num_tests * (70 + max_pause + 20);

    logic          clk;
    logic          reset_n;
    logic          zeroize_i;
    logic          enable_i;
    pwo_mode_e     mode_i;
    logic          accumulate_i;
    logic          sampler_valid_i;
    pwo_mem_addr_t base_addr_i;
    mem_data_t     mem_rd_data_i = '0;
    mem_data_t     pwm_a_rd_data_i = '0;
    mem_data_t     pwm_b_rd_data_i = '0;
    mem_if_t       mem_wr_req_o;
    mem_data_t     mem_wr_data_o;
    mem_if_t       mem_rd_req_o;
    mem_if_t       pwm_a_rd_req_o;
    mem_if_t       pwm_b_rd_req_o;
    logic          busy_o;
    logic          done_o;

    // ========================================================================
    // Memory models and bookkeeping
    // ========================================================================

    mem_data_t mem_a [0:(1 << mem_addr_width)-1];
    mem_data_t mem_b [0:(1 << mem_addr_width)-1];
    mem_data_t mem_c [0:(1 << mem_addr_width)-1];
    // Staged copy of memory c that loads in one cycle and stays as the old c for the model
    mem_data_t c_init [0:(1 << mem_addr_width)-1];
    logic      c_load = 1'b0;

    int rd_cycles [$];
    int issued;
    int cycle = 0;
    int last_wr_cycle = 0;
    int mon_errors = 0;
    int chk_errors = 0;
    int wr_total = 0;
    int done_total = 0;
    int c_rd_total = 0;
    int tests_run = 0;
    int tests_failed = 0;

    pwo_top i_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .enable_i       (enable_i),
        .mode_i         (mode_i),
        .accumulate_i   (accumulate_i),
        .sampler_valid_i(sampler_valid_i),
        .base_addr_i    (base_addr_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .pwm_a_rd_data_i(pwm_a_rd_data_i),
        .pwm_b_rd_data_i(pwm_b_rd_data_i),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .mem_rd_req_o   (mem_rd_req_o),
        .pwm_a_rd_req_o (pwm_a_rd_req_o),
        .pwm_b_rd_req_o (pwm_b_rd_req_o),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // One-cycle registered reads while memory c also takes every write
    always @(posedge clk) begin
        if (pwm_a_rd_req_o.rd_wr_en == rw_read) begin
            pwm_a_rd_data_i <= mem_a[pwm_a_rd_req_o.addr];
        end
        if (pwm_b_rd_req_o.rd_wr_en == rw_read) begin
            pwm_b_rd_data_i <= mem_b[pwm_b_rd_req_o.addr];
        end
        if (mem_rd_req_o.rd_wr_en == rw_read) begin
            mem_rd_data_i <= mem_c[mem_rd_req_o.addr];
        end
        if (c_load) begin
            mem_c <= c_init;
        end else if (mem_wr_req_o.rd_wr_en == rw_write) begin
            mem_c[mem_wr_req_o.addr] <= mem_wr_data_o;
        end
    end

    // Read to write latency, done timing and the run watchdog
    always @(posedge clk) begin
        cycle++;
        if (reset_n) begin
            if (pwm_a_rd_req_o.rd_wr_en == rw_read) begin
                rd_cycles.push_back(cycle);
            end
            if (mem_rd_req_o.rd_wr_en == rw_read) begin
                c_rd_total++;
            end
            if (mem_wr_req_o.rd_wr_en == rw_write) begin
                wr_total++;
                last_wr_cycle = cycle;
                if (rd_cycles.size() == 0) begin
                    mon_errors++;
                    $display("Write at cycle %0d has no matching read", cycle);
                end else begin
                    issued = rd_cycles.pop_front();
                    if (cycle - issued != 5) begin
                        mon_errors++;
                        $display("[FAIL] write latency: expected 5, got %0h", cycle - issued);
                    end
                end
            end
            if (done_o) begin
                done_total++;
                if (cycle - last_wr_cycle != 1) begin
                    mon_errors++;
                    $display("[FAIL] done_o delay after last write: expected 1, got %0h",
                             cycle - last_wr_cycle);
                end
            end
            // Reads in flight are dropped by zeroize
            if (zeroize_i) begin
                rd_cycles.delete();
            end
        end
        if (cycle >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    `include "pwo_tests.svh"

    initial begin
        void'($urandom(35835));
        reset_n         = 1'b0;
        zeroize_i       = 1'b0;
        enable_i        = 1'b0;
        mode_i          = pwm;
        accumulate_i    = 1'b0;
        sampler_valid_i = 1'b1;
        base_addr_i     = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        test_reset();
        // Bases are a, b, c
        test_pointwise("pointwise add", pwa, 1'b0, {10'h000, 10'h040, 10'h080}, 1'b0);
        test_pointwise("pointwise sub", pws, 1'b0, {10'h100, 10'h140, 10'h180}, 1'b0);
        test_pointwise("mul accumulate", pwm, 1'b1, {10'h300, 10'h340, 10'h380}, 1'b0);
        // Stale c read data is still on the port here
        test_pointwise("pointwise mul", pwm, 1'b0, {10'h200, 10'h240, 10'h280}, 1'b0);
        // c region wraps past the top of memory
        test_pointwise("mul acc paused", pwm, 1'b1, {10'h013, 10'h2a7, 10'h3c5}, 1'b1);
        test_zeroize();
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
